//--- Bender.yml
package:
  name: multilane_pcs_rx

sources:
  - files:
      - design/pcs_rx_pkg.sv
      - design/xgmii_lane_if.sv
      - design/lane_descrambler_bank.sv
      - design/block_decoder.sv
      - design/rx_frame_control.sv
      - design/multilane_pcs_rx.sv
  - target: test
    files:
      - verif/tb_multilane_pcs_rx.sv

//--- compile.f
design/pcs_rx_pkg.sv
design/xgmii_lane_if.sv
design/lane_descrambler_bank.sv
design/block_decoder.sv
design/rx_frame_control.sv
design/multilane_pcs_rx.sv
verif/tb_multilane_pcs_rx.sv

//--- design/block_decoder.sv
// 64b/66b block decoder for one lane
`timescale 1ns/10ps

module block_decoder
    import pcs_rx_pkg::*;
(
    input  logic                clk_156,
    input  logic                async_reset_n,
    input  logic                valid_i,
    input  pcs_block_t          block_i,
    xgmii_lane_if.source        lane_o
);

    logic [7:0]            blk_type;
    logic [block_bits-1:0] body;
    logic                  is_ctrl;
    logic                  term_hit;
    logic [2:0]            term_len;

    xgmii_word_t dec_rxd;
    xgmii_ctrl_t dec_rxc;
    logic        dec_start;
    logic        dec_term;
    logic        dec_err;

    assign is_ctrl  = (block_i.header == hdr_ctrl);
    assign blk_type = block_i.payload[7:0];
    // Payload without the type byte
    assign body     = block_i.payload >> 8;

    // Terminate type to data byte count
    always_comb begin
        term_hit = 1'b1;
        term_len = 3'd0;
        case (blk_type)
            type_term_0: term_len = 3'd0;
            type_term_1: term_len = 3'd1;
            type_term_2: term_len = 3'd2;
            type_term_3: term_len = 3'd3;
            type_term_4: term_len = 3'd4;
            type_term_5: term_len = 3'd5;
            type_term_6: term_len = 3'd6;
            type_term_7: term_len = 3'd7;
            default:     term_hit = 1'b0;
        endcase
    end

    //////////////////////////////
    // Block to XGMII
    //////////////////////////////
    always_comb begin
        dec_rxd   = {bytes_per_block{char_error}};
        dec_rxc   = '1;
        dec_start = 1'b0;
        dec_term  = 1'b0;
        dec_err   = 1'b0;
        if (block_i.header == hdr_data) begin
            dec_rxd = block_i.payload;
            dec_rxc = '0;
        end else if (is_ctrl && blk_type == type_idle) begin
            dec_rxd = {bytes_per_block{char_idle}};
        end else if (is_ctrl && blk_type == type_start) begin
            dec_rxd   = {block_i.payload[block_bits-1:8], char_start};
            dec_rxc   = 8'h01;
            dec_start = 1'b1;
        end else if (is_ctrl && term_hit) begin
            // Data bytes first, then T, then idles
            for (int b = 0; b < bytes_per_block; b++) begin
                if (b < term_len) begin
                    dec_rxd[8*b +: 8] = body[8*b +: 8];
                    dec_rxc[b]        = 1'b0;
                end else if (b == term_len) begin
                    dec_rxd[8*b +: 8] = char_term;
                end else begin
                    dec_rxd[8*b +: 8] = char_idle;
                end
            end
            dec_term = 1'b1;
        end else begin
            dec_err = 1'b1;
        end
    end

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            lane_o.valid        <= 1'b0;
            lane_o.is_start     <= 1'b0;
            lane_o.is_terminate <= 1'b0;
            lane_o.is_error     <= 1'b0;
        end else begin
            lane_o.valid <= valid_i;
            if (valid_i) begin
                lane_o.is_start     <= dec_start;
                lane_o.is_terminate <= dec_term;
                lane_o.is_error     <= dec_err;
            end
        end
    end

    always_ff @(posedge clk_156) begin
        if (valid_i) begin
            lane_o.rxd <= dec_rxd;
            lane_o.rxc <= dec_rxc;
        end
    end

    a_err_all_ctrl: assert property (
        @(posedge clk_156) disable iff (!async_reset_n)
        lane_o.is_error |-> (lane_o.rxc == '1)
    );

endmodule

//--- design/lane_descrambler_bank.sv
// Four-lane descrambler bank
`timescale 1ns/10ps

module lane_descrambler_bank
    import pcs_rx_pkg::*;
(
    input  logic       clk_156,
    input  logic       async_reset_n,
    input  logic       valid_i,
    input  pcs_block_t block_i [num_lanes],
    input  logic       bypass_i,
    output logic       valid_o,
    output pcs_block_t block_o [num_lanes]
);

    // Scrambled lane 3 payload of the last valid beat
    logic [block_bits-1:0] hist_q;
    logic [block_bits-1:0] prev_payload [num_lanes];
    logic [block_bits-1:0] descr        [num_lanes];

    // Self-synchronizing descrambler over one block, low bit first
    function automatic logic [block_bits-1:0] descramble(
        input logic [block_bits-1:0] cur,
        input logic [block_bits-1:0] prev
    );
        logic [2*block_bits-1:0] stream;
        logic [block_bits-1:0]   res;
        stream = {cur, prev};
        for (int i = 0; i < block_bits; i++) begin
            res[i] = stream[block_bits+i]
                   ^ stream[block_bits+i-scr_tap_a]
                   ^ stream[block_bits+i-scr_tap_b];
        end
        return res;
    endfunction

    //////////////////////////////
    // History chain across lanes
    //////////////////////////////
    always_comb begin
        prev_payload[0] = hist_q;
        for (int k = 1; k < num_lanes; k++) begin
            prev_payload[k] = block_i[k-1].payload;
        end
    end

    always_comb begin
        for (int k = 0; k < num_lanes; k++) begin
            descr[k] = descramble(block_i[k].payload, prev_payload[k]);
        end
    end

    // History keeps running under bypass so re-enabling resyncs at once
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_o <= 1'b0;
            hist_q  <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                hist_q <= block_i[num_lanes-1].payload;
            end
        end
    end

    always_ff @(posedge clk_156) begin
        if (valid_i) begin
            for (int k = 0; k < num_lanes; k++) begin
                block_o[k].header  <= block_i[k].header;
                block_o[k].payload <= bypass_i ? block_i[k].payload : descr[k];
            end
        end
    end

    a_valid_known: assert property (
        @(posedge clk_156) disable iff (!async_reset_n) !$isunknown(valid_i)
    );

endmodule

//--- design/multilane_pcs_rx.sv
// Four-lane 64b/66b PCS receive top
`timescale 1ns/10ps

module multilane_pcs_rx
    import pcs_rx_pkg::*;
(
    input  logic        clk_156,
    input  logic        async_reset_n,

    // Block input, one strobe for all lanes
    input  logic        rx_valid_i,
    input  pcs_block_t  rx_block_i [num_lanes],

    // Control
    input  logic        bypass_descram_i,
    input  logic        clear_errblk_i,

    // Decoded XGMII
    output logic        xgmii_valid_o,
    output xgmii_word_t xgmii_rxd_o [num_lanes],
    output xgmii_ctrl_t xgmii_rxc_o [num_lanes],

    // Frame status
    output logic        frame_start_o,
    output logic        frame_end_o,
    output logic        seq_error_o,
    output err_count_t  errd_blks_o
);

    logic       descr_valid;
    pcs_block_t descr_block [num_lanes];

    xgmii_lane_if lane_if [num_lanes] ();

    //////////////////////////////
    // Descrambler
    //////////////////////////////
    lane_descrambler_bank i_descrambler_bank (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .valid_i       (rx_valid_i),
        .block_i       (rx_block_i),
        .bypass_i      (bypass_descram_i),
        .valid_o       (descr_valid),
        .block_o       (descr_block)
    );

    // One decoder per lane
    for (genvar g = 0; g < num_lanes; g++) begin : g_dec
        block_decoder i_block_decoder (
            .clk_156       (clk_156),
            .async_reset_n (async_reset_n),
            .valid_i       (descr_valid),
            .block_i       (descr_block[g]),
            .lane_o        (lane_if[g])
        );
    end

    //////////////////////////////
    // Frame control
    //////////////////////////////
    rx_frame_control i_frame_control (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .lanes_i        (lane_if),
        .clear_errblk_i (clear_errblk_i),
        .xgmii_valid_o  (xgmii_valid_o),
        .xgmii_rxd_o    (xgmii_rxd_o),
        .xgmii_rxc_o    (xgmii_rxc_o),
        .frame_start_o  (frame_start_o),
        .frame_end_o    (frame_end_o),
        .seq_error_o    (seq_error_o),
        .errd_blks_o    (errd_blks_o)
    );

endmodule

//--- design/pcs_rx_pkg.sv
// Multilane PCS receive definitions

package pcs_rx_pkg;

    //////////////////////////////
    // Lane geometry
    //////////////////////////////
    localparam int num_lanes       = 4;
    localparam int block_bits      = 64;
    localparam int bytes_per_block = 8;

    // Descrambler taps for 1 + x^39 + x^58
    localparam int scr_tap_a = 39;
    localparam int scr_tap_b = 58;

    //////////////////////////////
    // 64b/66b codes
    //////////////////////////////
    localparam logic [1:0] hdr_data = 2'b01;
    localparam logic [1:0] hdr_ctrl = 2'b10;

    localparam logic [7:0] type_idle   = 8'h1E;
    localparam logic [7:0] type_start  = 8'h78;
    // Terminate type k carries k data bytes
    localparam logic [7:0] type_term_0 = 8'h87;
    localparam logic [7:0] type_term_1 = 8'h99;
    localparam logic [7:0] type_term_2 = 8'hAA;
    localparam logic [7:0] type_term_3 = 8'hB4;
    localparam logic [7:0] type_term_4 = 8'hCC;
    localparam logic [7:0] type_term_5 = 8'hD2;
    localparam logic [7:0] type_term_6 = 8'hE1;
    localparam logic [7:0] type_term_7 = 8'hFF;

    // XGMII control characters
    localparam logic [7:0] char_idle  = 8'h07;
    localparam logic [7:0] char_start = 8'hFB;
    localparam logic [7:0] char_term  = 8'hFD;
    localparam logic [7:0] char_error = 8'hFE;

    // One received block, header on top
    typedef struct packed {
        logic [1:0]            header;
        logic [block_bits-1:0] payload;
    } pcs_block_t;

    typedef logic [block_bits-1:0]      xgmii_word_t;
    typedef logic [bytes_per_block-1:0] xgmii_ctrl_t;
    typedef logic [7:0]                 err_count_t;

endpackage

//--- design/rx_frame_control.sv
// Receive frame control across lanes
`timescale 1ns/10ps

module rx_frame_control
    import pcs_rx_pkg::*;
(
    input  logic         clk_156,
    input  logic         async_reset_n,
    xgmii_lane_if.sink   lanes_i [num_lanes],
    input  logic         clear_errblk_i,
    output logic         xgmii_valid_o,
    output xgmii_word_t  xgmii_rxd_o [num_lanes],
    output xgmii_ctrl_t  xgmii_rxc_o [num_lanes],
    output logic         frame_start_o,
    output logic         frame_end_o,
    output logic         seq_error_o,
    output err_count_t   errd_blks_o
);

    logic [num_lanes-1:0] lane_valid;
    logic [num_lanes-1:0] lane_start;
    logic [num_lanes-1:0] lane_term;
    logic [num_lanes-1:0] lane_err;
    xgmii_word_t          lane_rxd [num_lanes];
    xgmii_ctrl_t          lane_rxc [num_lanes];

    logic                           beat_valid;
    logic                           in_frame_q;
    logic                           frame_walk;
    logic                           start_seen;
    logic                           end_seen;
    logic                           seq_seen;
    logic [$clog2(num_lanes+1)-1:0] err_lanes;
    logic [$bits(err_count_t):0]    err_sum;

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        assign lane_valid[g] = lanes_i[g].valid;
        assign lane_start[g] = lanes_i[g].is_start;
        assign lane_term[g]  = lanes_i[g].is_terminate;
        assign lane_err[g]   = lanes_i[g].is_error;
        assign lane_rxd[g]   = lanes_i[g].rxd;
        assign lane_rxc[g]   = lanes_i[g].rxc;
    end

    assign beat_valid = |lane_valid;

    //////////////////////////////
    // Start/terminate chaining
    //////////////////////////////
    always_comb begin
        frame_walk = in_frame_q;
        start_seen = 1'b0;
        end_seen   = 1'b0;
        seq_seen   = 1'b0;
        err_lanes  = '0;
        for (int k = 0; k < num_lanes; k++) begin
            if (lane_valid[k]) begin
                if (lane_start[k]) begin
                    // Second start without a terminate
                    if (frame_walk) seq_seen = 1'b1;
                    else begin
                        frame_walk = 1'b1;
                        start_seen = 1'b1;
                    end
                end else if (lane_term[k]) begin
                    if (!frame_walk) seq_seen = 1'b1;
                    else begin
                        frame_walk = 1'b0;
                        end_seen   = 1'b1;
                    end
                end
                err_lanes = err_lanes + lane_err[k];
            end
        end
    end

    assign err_sum = errd_blks_o + err_lanes;

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            in_frame_q    <= 1'b0;
            xgmii_valid_o <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            seq_error_o   <= 1'b0;
            errd_blks_o   <= '0;
        end else begin
            xgmii_valid_o <= beat_valid;
            frame_start_o <= beat_valid & start_seen;
            frame_end_o   <= beat_valid & end_seen;
            seq_error_o   <= beat_valid & seq_seen;
            if (beat_valid) in_frame_q <= frame_walk;
            // Clear wins over a same-cycle increment
            if (clear_errblk_i) begin
                errd_blks_o <= '0;
            end else if (beat_valid) begin
                errd_blks_o <= err_sum[$bits(err_count_t)] ? '1
                                                           : err_sum[$bits(err_count_t)-1:0];
            end
        end
    end

    always_ff @(posedge clk_156) begin
        if (beat_valid) begin
            for (int k = 0; k < num_lanes; k++) begin
                xgmii_rxd_o[k] <= lane_rxd[k];
                xgmii_rxc_o[k] <= lane_rxc[k];
            end
        end
    end

    a_count_monotonic: assert property (
        @(posedge clk_156) disable iff (!async_reset_n)
        !$past(clear_errblk_i) |-> (errd_blks_o >= $past(errd_blks_o))
    );

endmodule

//--- design/xgmii_lane_if.sv
// Decoded XGMII lane
`timescale 1ns/10ps

interface xgmii_lane_if
    import pcs_rx_pkg::*;
();

    // Strobe only, the sink never stalls
    logic        valid;
    xgmii_word_t rxd;
    xgmii_ctrl_t rxc;

    // Block classification from the decoder
    logic        is_start;
    logic        is_terminate;
    logic        is_error;

    modport source (
        output valid, rxd, rxc, is_start, is_terminate, is_error
    );

    modport sink (
        input valid, rxd, rxc, is_start, is_terminate, is_error
    );

endinterface

//--- verif/tb_multilane_pcs_rx.sv
// Multilane PCS receive testbench
`timescale 1ns/10ps

module tb_multilane_pcs_rx
    import pcs_rx_pkg::*;
();

    typedef enum logic [1:0] {blk_plain, blk_start, blk_term, blk_error} blk_kind_t;

    typedef struct packed {
        xgmii_word_t rxd;
        xgmii_ctrl_t rxc;
        blk_kind_t   kind;
    } lane_exp_t;

    logic        clk_156 = 1'b0;
    logic        async_reset_n;
    logic        rx_valid_i;
    pcs_block_t  rx_block [num_lanes];
    logic        bypass_descram_i;
    logic        clear_errblk_i;
    logic        xgmii_valid_o;
    xgmii_word_t xgmii_rxd_o [num_lanes];
    xgmii_ctrl_t xgmii_rxc_o [num_lanes];
    logic        frame_start_o;
    logic        frame_end_o;
    logic        seq_error_o;
    err_count_t  errd_blks_o;

    // Encoder side state and reference frame model
    pcs_block_t            tx_stream [$];
    logic [block_bits-1:0] tx_hist      = '0;
    logic                  ref_in_frame = 1'b0;
    err_count_t            ref_count    = '0;
    int                    cycle        = 0;

    // Expected beats, four lanes per beat in exp_lane
    lane_exp_t  exp_lane  [$];
    logic [2:0] exp_flags [$];
    err_count_t exp_count [$];
    int         exp_cycle [$];

    always #5 clk_156 = ~clk_156;

    always @(posedge clk_156) cycle <= cycle + 1;

    multilane_pcs_rx i_dut (
        .clk_156          (clk_156),
        .async_reset_n    (async_reset_n),
        .rx_valid_i       (rx_valid_i),
        .rx_block_i       (rx_block),
        .bypass_descram_i (bypass_descram_i),
        .clear_errblk_i   (clear_errblk_i),
        .xgmii_valid_o    (xgmii_valid_o),
        .xgmii_rxd_o      (xgmii_rxd_o),
        .xgmii_rxc_o      (xgmii_rxc_o),
        .frame_start_o    (frame_start_o),
        .frame_end_o      (frame_end_o),
        .seq_error_o      (seq_error_o),
        .errd_blks_o      (errd_blks_o)
    );

    task automatic report_failure();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_rxd(input int lane, input xgmii_word_t got, input xgmii_word_t exp);
        if (got !== exp) begin
            $display("error: xgmii_rxd_o[%0d] got %h expected %h", lane, got, exp);
            report_failure();
        end
    endtask

    task automatic check_rxc(input int lane, input xgmii_ctrl_t got, input xgmii_ctrl_t exp);
        if (got !== exp) begin
            $display("error: xgmii_rxc_o[%0d] got %h expected %h", lane, got, exp);
            report_failure();
        end
    endtask

    task automatic check_count(input err_count_t got, input err_count_t exp);
        if (got !== exp) begin
            $display("error: errd_blks_o got %h expected %h", got, exp);
            report_failure();
        end
    endtask

    // Flags packed as start, end, seq
    task automatic check_flags(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("error: frame_start_o/frame_end_o/seq_error_o got %h expected %h", got, exp);
            report_failure();
        end
    endtask

    //////////////////////////////
    // Encoder and scrambler model
    //////////////////////////////
    function automatic logic [7:0] term_type(input int k);
        case (k)
            0:       return type_term_0;
            1:       return type_term_1;
            2:       return type_term_2;
            3:       return type_term_3;
            4:       return type_term_4;
            5:       return type_term_5;
            6:       return type_term_6;
            default: return type_term_7;
        endcase
    endfunction

    // Scrambler 1 + x^39 + x^58, fed back from the scrambled line
    function automatic logic [block_bits-1:0] scramble_block(
        input logic [block_bits-1:0] data,
        input logic [block_bits-1:0] prev
    );
        logic [2*block_bits-1:0] sreg;
        sreg = {{block_bits{1'b0}}, prev};
        for (int i = 0; i < block_bits; i++) begin
            sreg[block_bits+i] = data[i] ^ sreg[block_bits+i-scr_tap_a]
                               ^ sreg[block_bits+i-scr_tap_b];
        end
        return sreg[2*block_bits-1:block_bits];
    endfunction

    function automatic logic [block_bits-1:0] random_word();
        return {$urandom(), $urandom()};
    endfunction

    // Seven random bytes above the type byte
    function automatic logic [block_bits-9:0] random_body();
        logic [block_bits-1:0] w;
        w = random_word();
        return w[block_bits-1:8];
    endfunction

    task automatic add_idles(input int n);
        repeat (n) tx_stream.push_back({hdr_ctrl, 56'h0, type_idle});
    endtask

    task automatic add_start();
        tx_stream.push_back({hdr_ctrl, random_body(), type_start});
    endtask

    task automatic add_term(input int k);
        tx_stream.push_back({hdr_ctrl, random_body(), term_type(k)});
    endtask

    // Bad headers and unknown control types
    task automatic add_error_block(input int idx);
        case (idx % 4)
            0:       tx_stream.push_back({2'b00, random_word()});
            1:       tx_stream.push_back({2'b11, random_word()});
            2:       tx_stream.push_back({hdr_ctrl, random_body(), 8'h55});
            default: tx_stream.push_back({hdr_ctrl, random_body(), 8'h00});
        endcase
    endtask

    task automatic add_frame();
        add_start();
        repeat ($urandom_range(0, 3)) tx_stream.push_back({hdr_data, random_word()});
        add_term($urandom_range(0, 7));
    endtask

    //////////////////////////////
    // Reference decode
    //////////////////////////////
    function automatic lane_exp_t decode_reference(input pcs_block_t blk);
        lane_exp_t  e;
        logic [7:0] t;
        int         k;
        e.rxd  = {bytes_per_block{char_error}};
        e.rxc  = '1;
        e.kind = blk_error;
        t      = blk.payload[7:0];
        k      = -1;
        for (int j = 0; j < 8; j++) begin
            if (term_type(j) == t) k = j;
        end
        if (blk.header == hdr_data) begin
            e.rxd  = blk.payload;
            e.rxc  = '0;
            e.kind = blk_plain;
        end else if (blk.header == hdr_ctrl && t == type_idle) begin
            e.rxd  = {bytes_per_block{char_idle}};
            e.kind = blk_plain;
        end else if (blk.header == hdr_ctrl && t == type_start) begin
            e.rxd  = {blk.payload[block_bits-1:8], char_start};
            e.rxc  = 8'h01;
            e.kind = blk_start;
        end else if (blk.header == hdr_ctrl && k >= 0) begin
            // Byte b of the lane is payload byte b+1 while data lasts
            for (int b = 0; b < bytes_per_block; b++) begin
                if (b < k) begin
                    e.rxd[8*b +: 8] = blk.payload[8*(b+1) +: 8];
                    e.rxc[b]        = 1'b0;
                end else if (b == k) begin
                    e.rxd[8*b +: 8] = char_term;
                end else begin
                    e.rxd[8*b +: 8] = char_idle;
                end
            end
            e.kind = blk_term;
        end
        return e;
    endfunction

    // One beat of four lanes, expected results queued alongside
    task automatic send_beat(input bit gaps);
        pcs_block_t            blk;
        lane_exp_t             e;
        logic [block_bits-1:0] wire_pl;
        logic [2:0]            fl;
        int                    nerr;
        int                    sum;
        fl   = 3'b000;
        nerr = 0;
        for (int k = 0; k < num_lanes; k++) begin
            blk = tx_stream.pop_front();
            e   = decode_reference(blk);
            exp_lane.push_back(e);
            if (e.kind == blk_start) begin
                if (ref_in_frame) fl[0] = 1'b1;
                else begin
                    ref_in_frame = 1'b1;
                    fl[2]        = 1'b1;
                end
            end else if (e.kind == blk_term) begin
                if (!ref_in_frame) fl[0] = 1'b1;
                else begin
                    ref_in_frame = 1'b0;
                    fl[1]        = 1'b1;
                end
            end else if (e.kind == blk_error) begin
                nerr++;
            end
            wire_pl             = bypass_descram_i ? blk.payload
                                                   : scramble_block(blk.payload, tx_hist);
            tx_hist             = wire_pl;
            rx_block[k].header  = blk.header;
            rx_block[k].payload = wire_pl;
        end
        sum       = int'(ref_count) + nerr;
        ref_count = (sum > 255) ? 8'hFF : sum[7:0];
        exp_flags.push_back(fl);
        exp_count.push_back(ref_count);
        // Bank, decoder and controller registers
        exp_cycle.push_back(cycle + 3);
        rx_valid_i = 1'b1;
        @(posedge clk_156);
        #1;
        rx_valid_i = 1'b0;
        if (gaps) begin
            repeat ($urandom_range(0, 3)) begin
                @(posedge clk_156);
                #1;
            end
        end
    endtask

    task automatic flush_stream(input bit gaps);
        add_idles((num_lanes - tx_stream.size() % num_lanes) % num_lanes);
        while (tx_stream.size() != 0) send_beat(gaps);
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_flags.size() != 0 && t < 100) begin
            @(posedge clk_156);
            #1;
            t++;
        end
        if (exp_flags.size() != 0) begin
            $display("timed out waiting for %0d pending beats", exp_flags.size());
            report_failure();
        end
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////
    always @(negedge clk_156) begin : compare_outputs
        lane_exp_t e;
        int        exp_cyc;
        if (async_reset_n === 1'b1 && xgmii_valid_o === 1'b1) begin
            if (exp_flags.size() == 0) begin
                $display("xgmii_valid_o went high with no beat pending");
                report_failure();
            end else begin
                exp_cyc = exp_cycle.pop_front();
                if (exp_cyc != cycle) begin
                    $display("beat arrived at cycle %0d instead of %0d", cycle, exp_cyc);
                    report_failure();
                end
                for (int k = 0; k < num_lanes; k++) begin
                    e = exp_lane.pop_front();
                    check_rxd(k, xgmii_rxd_o[k], e.rxd);
                    check_rxc(k, xgmii_rxc_o[k], e.rxc);
                end
                check_flags({frame_start_o, frame_end_o, seq_error_o}, exp_flags.pop_front());
                check_count(errd_blks_o, exp_count.pop_front());
            end
        end else if (async_reset_n === 1'b1) begin
            check_flags({frame_start_o, frame_end_o, seq_error_o}, 3'b000);
        end
    end

    initial begin
        int seed_ret;
        seed_ret         = $urandom(32'h0924_db84);
        async_reset_n    = 1'b0;
        rx_valid_i       = 1'b0;
        bypass_descram_i = 1'b0;
        clear_errblk_i   = 1'b0;
        for (int k = 0; k < num_lanes; k++) rx_block[k] = '0;
        repeat (10) @(posedge clk_156);
        #1;
        async_reset_n = 1'b1;

        // Scrambled idles from a zero history
        add_idles(32);
        flush_stream(1'b0);
        wait_drain();

        // Random frames back to back
        repeat (40) begin
            add_frame();
            add_idles($urandom_range(0, 2));
        end
        flush_stream(1'b0);
        wait_drain();

        // Unscrambled run, then scrambling again
        bypass_descram_i = 1'b1;
        repeat (20) begin
            add_frame();
            add_idles($urandom_range(0, 2));
        end
        flush_stream(1'b0);
        bypass_descram_i = 1'b0;
        repeat (10) add_frame();
        flush_stream(1'b0);
        wait_drain();

        // Errors inside a frame, then saturation and clear
        add_start();
        add_error_block(2);
        add_term(3);
        for (int i = 0; i < 280; i++) add_error_block(i);
        flush_stream(1'b0);
        wait_drain();
        check_count(errd_blks_o, 8'hFF);
        clear_errblk_i = 1'b1;
        @(posedge clk_156);
        #1;
        clear_errblk_i = 1'b0;
        ref_count      = '0;
        check_count(errd_blks_o, 8'h00);

        // Terminate outside a frame, second start inside one
        add_term(2);
        add_start();
        add_start();
        tx_stream.push_back({hdr_data, random_word()});
        add_term(5);
        add_idles(3);
        add_term(0);
        flush_stream(1'b0);
        wait_drain();

        // Random gaps in the valid strobe
        repeat (30) begin
            add_frame();
            add_idles($urandom_range(0, 1));
        end
        flush_stream(1'b1);
        wait_drain();

        $display("TEST PASS");
        $finish;
    end

endmodule
